/* dv/miniRvCore_asserts.sv */
`default_nettype none

module miniRvCore_asserts (
   input wire logic        clk,
   input wire logic        rstn,
   input wire logic        busReq,
   input wire logic        busWrite,
   input wire logic        busValid,
   input wire logic [31:0] busAddr,
   input wire logic [31:0] storeData
);

   // a store is always part of a request
   writeNeedsReq: assert property (@(posedge clk) disable iff (!rstn)
      busWrite |-> busReq)
      else $error("busWrite high without busReq");

   // request fields frozen until memory answers
   reqHeld: assert property (@(posedge clk) disable iff (!rstn)
      (busReq && !busValid) |=> (busReq && $stable(busWrite) && $stable(busAddr)
         && (!busWrite || $stable(storeData))))
      else $error("bus request changed before busValid");

   // no request out of reset
   quietInReset: assert property (@(posedge clk)
      !rstn |=> !busReq)
      else $error("busReq high during reset");

endmodule

bind miniRvCore miniRvCore_asserts asserts0 (
   .clk       (clk),
   .rstn      (rstn),
   .busReq    (busReq),
   .busWrite  (busWrite),
   .busValid  (busValid),
   .busAddr   (busAddr),
   .storeData (storeData)
);

`default_nettype wire

/* dv/miniRvCore_tb.sv */
`default_nettype none

module miniRvCore_tb;

   localparam int numRows       = 16;
   localparam int timeoutCycles = 20 * numRows + 40;
   localparam int pauseCycles   = 5;

   // opcode field values
   localparam logic [6:0] luiCode   = 7'b0110111;
   localparam logic [6:0] addCode   = 7'b0110011;
   localparam logic [6:0] storeCode = 7'b0100011;

   logic        clk;
   logic        rstn;
   logic        runEn;
   logic        busValid;
   logic [31:0] busData;
   logic        busReq;
   logic        busWrite;
   logic [31:0] busAddr;
   logic [31:0] storeData;

   // program table, indexed by fetch pc
   logic [31:0] progInstr [numRows];
   bit          storeExp  [numRows];
   logic [31:0] expAddr   [numRows];
   logic [31:0] expData   [numRows];
   bit          pauseAfter [numRows];
   int          rowCount = 0;
   int          cycleCount = 0;

   miniRvCore dut0 (
      .clk       (clk),
      .rstn      (rstn),
      .runEn     (runEn),
      .busValid  (busValid),
      .busData   (busData),
      .busReq    (busReq),
      .busWrite  (busWrite),
      .busAddr   (busAddr),
      .storeData (storeData)
   );

   always #2 clk = ~clk;

   always @(posedge clk) begin
      cycleCount++;
      if (cycleCount >= timeoutCycles) begin
         $display("timeout after %0d cycles without finishing the program", cycleCount);
         $display("Test FAILED");
         $fatal(1, "timeout");
      end
   end

   function automatic logic [31:0] encLui(input logic [4:0] rd, input logic [19:0] imm);
      encLui = {imm, rd, luiCode};
   endfunction

   function automatic logic [31:0] encAdd(input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
      encAdd = {7'b0, rs2, rs1, 3'b000, rd, addCode};
   endfunction

   function automatic logic [31:0] encSw(input logic [4:0] rs2, input logic [4:0] rs1,
                                         input logic [11:0] imm);
      encSw = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], storeCode};
   endfunction

   task automatic addRow(input logic [31:0] word, input bit isSt, input logic [31:0] addr,
                         input logic [31:0] data, input bit pause);
      progInstr[rowCount]  = word;
      storeExp[rowCount]   = isSt;
      expAddr[rowCount]    = addr;
      expData[rowCount]    = data;
      pauseAfter[rowCount] = pause;
      rowCount++;
   endtask

   task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp) else begin
         $display("error: %s expected %h actual %h", name, exp, act);
         $display("Test FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic waitRequest();
      do begin
         @(posedge clk);
         #1;
      end while (!busReq);
   endtask

   // memory answers after 1 to 3 cycles
   task automatic answerRequest(input logic [31:0] data);
      int delay;
      delay = 1 + int'($urandom % 3);
      repeat (delay) @(posedge clk);
      #1;
      busValid = 1'b1;
      busData  = data;
      @(posedge clk);
      #1;
      busValid = 1'b0;
      busData  = $urandom;
   endtask

   initial begin
      int row;
      void'($urandom(32'h4010_6a00));
      clk      = 1'b0;
      rstn     = 1'b0;
      runEn    = 1'b0;
      busValid = 1'b0;
      busData  = '0;

      addRow(encLui(5'd1, 20'h12345), 1'b0, '0, '0, 1'b0);
      addRow(encSw(5'd1, 5'd0, 12'h040), 1'b1, 32'h0000_0040, 32'h1234_5000, 1'b0);
      addRow(encLui(5'd2, 20'hFFFFF), 1'b0, '0, '0, 1'b0);
      addRow(encLui(5'd3, 20'h00002), 1'b0, '0, '0, 1'b0);
      // sum wraps past 32 bits
      addRow(encAdd(5'd4, 5'd2, 5'd3), 1'b0, '0, '0, 1'b0);
      addRow(encLui(5'd5, 20'h00010), 1'b0, '0, '0, 1'b0);
      // negative offset from x5
      addRow(encSw(5'd4, 5'd5, 12'hFF0), 1'b1, 32'h0000_FFF0, 32'h0000_1000, 1'b0);
      addRow(encLui(5'd0, 20'hABCDE), 1'b0, '0, '0, 1'b0);
      addRow(encAdd(5'd0, 5'd1, 5'd2), 1'b0, '0, '0, 1'b0);
      addRow(encSw(5'd0, 5'd0, 12'h008), 1'b1, 32'h0000_0008, 32'h0000_0000, 1'b0);
      // unknown opcodes, x1 must survive
      addRow(32'h0020_8093, 1'b0, '0, '0, 1'b0);
      addRow(32'hFFFF_FFFF, 1'b0, '0, '0, 1'b0);
      addRow(encSw(5'd1, 5'd5, 12'h004), 1'b1, 32'h0001_0004, 32'h1234_5000, 1'b1);
      addRow(encSw(5'd2, 5'd0, 12'h000), 1'b1, 32'h0000_0000, 32'hFFFF_F000, 1'b0);
      addRow(encAdd(5'd6, 5'd1, 5'd4), 1'b0, '0, '0, 1'b0);
      addRow(encSw(5'd6, 5'd3, 12'h7FC), 1'b1, 32'h0000_27FC, 32'h1234_6000, 1'b0);

      repeat (10) @(posedge clk);
      #1;
      rstn  = 1'b1;
      runEn = 1'b1;

      for (row = 0; row < numRows; row++) begin
         waitRequest();
         checkValue($sformatf("row %0d fetch busWrite", row), 32'd0, 32'(busWrite));
         checkValue($sformatf("row %0d fetch busAddr", row), 32'(row), busAddr);
         answerRequest(progInstr[row]);

         if (storeExp[row]) begin
            waitRequest();
            checkValue($sformatf("row %0d store busWrite", row), 32'd1, 32'(busWrite));
            checkValue($sformatf("row %0d store busAddr", row), expAddr[row], busAddr);
            checkValue($sformatf("row %0d storeData", row), expData[row], storeData);
            answerRequest(32'hDEAD_BEEF);
         end

         // hold fetch off right after the store
         if (pauseAfter[row]) begin
            runEn = 1'b0;
            repeat (pauseCycles) begin
               @(posedge clk);
               #1;
               checkValue($sformatf("row %0d busReq with runEn low", row), 32'd0,
                          32'(busReq));
            end
            runEn = 1'b1;
         end
      end

      // pc keeps counting after the last row
      waitRequest();
      checkValue("final fetch busWrite", 32'd0, 32'(busWrite));
      checkValue("final fetch busAddr", 32'(numRows), busAddr);

      $display("Test OK");
      $finish;
   end

endmodule

`default_nettype wire

/* miniRvCore.f */
verilog/corePkg.sv
verilog/busControl.sv
verilog/instrExec.sv
verilog/regFile.sv
verilog/miniRvCore.sv
dv/miniRvCore_asserts.sv
dv/miniRvCore_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the miniRvCore testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --assert --timing \
   --top-module miniRvCore_tb \
   -f miniRvCore.f

# a failing run still has to reach the log search below
./obj_dir/VminiRvCore_tb > sim.log 2>&1 || true

cat sim.log

if grep -q "Test FAILED" sim.log; then
   echo "simulation failed"
   exit 1
fi

if ! grep -q "Test OK" sim.log; then
   echo "simulation ended without a result"
   exit 1
fi

exit 0

/* verilog/busControl.sv */
`default_nettype none

module busControl
   import corePkg::*;
#(
   parameter logic [xlen-1:0] resetPc = '0
) (
   input  logic            clk,
   input  logic            rstn,
   input  logic            runEn,
   input  logic            busValid,
   input  logic [xlen-1:0] busData,
   input  logic            isStore,
   input  logic [xlen-1:0] storeAddr,
   input  logic [xlen-1:0] storeValue,
   output logic            busReq,
   output logic            busWrite,
   output logic [xlen-1:0] busAddr,
   output logic [xlen-1:0] storeData,
   output logic [xlen-1:0] instr,
   output logic            execStrobe
);

   busState_t       state;
   logic [xlen-1:0] pc;

   logic            startFetch;
   logic            fetchDone;
   logic            startStore;
   logic            storeDone;

   // phase boundaries
   assign startFetch = (state == sIdle) && runEn;
   assign fetchDone  = (state == sFetch) && busValid;
   assign startStore = (state == sExec) && isStore;
   assign storeDone  = (state == sStore) && busValid;

   // exactly one cycle per fetched instruction
   assign execStrobe = (state == sExec);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state    <= sIdle;
         busReq   <= 1'b0;
         busWrite <= 1'b0;
         pc       <= resetPc;
      end
      else begin
         case (state)
            sIdle: begin
               if (startFetch) begin
                  state  <= sFetch;
                  busReq <= 1'b1;
               end
            end
            sFetch: begin
               if (fetchDone) begin
                  state  <= sExec;
                  busReq <= 1'b0;
                  pc     <= pc + 1'b1;
               end
            end
            sExec: begin
               if (startStore) begin
                  state    <= sStore;
                  busReq   <= 1'b1;
                  busWrite <= 1'b1;
               end
               else begin
                  state <= sIdle;
               end
            end
            sStore: begin
               if (storeDone) begin
                  state    <= sIdle;
                  busReq   <= 1'b0;
                  busWrite <= 1'b0;
               end
            end
            default: begin
               state <= sIdle;
            end
         endcase
      end
   end

   // bus payload, held for the whole request
   always_ff @(posedge clk) begin
      if (startFetch) begin
         busAddr <= pc;
      end
      else if (startStore) begin
         busAddr <= storeAddr;
      end
   end

   // store value latched here since the register file may change under it
   always_ff @(posedge clk) begin
      if (startStore) begin
         storeData <= storeValue;
      end
   end

   always_ff @(posedge clk) begin
      if (fetchDone) begin
         instr <= busData;
      end
   end

endmodule

`default_nettype wire

/* verilog/corePkg.sv */
`default_nettype none

package corePkg;

   // data path and address width
   localparam int xlen = 32;

   // register index width, 32 registers
   localparam int regAddrW = 5;

   // 7-bit opcode field, anything else runs as a no-op
   typedef enum logic [6:0] {
      opLui   = 7'b0110111,
      opAdd   = 7'b0110011,
      opStore = 7'b0100011
   } opcode_t;

   // sequencer states
   typedef enum logic [1:0] {
      sIdle,
      sFetch,
      sExec,
      sStore
   } busState_t;

endpackage

`default_nettype wire

/* verilog/instrExec.sv */
`default_nettype none

module instrExec
   import corePkg::*;
(
   input  logic [xlen-1:0]     instr,
   input  logic                execStrobe,
   input  logic [xlen-1:0]     rs1Data,
   input  logic [xlen-1:0]     rs2Data,
   output logic [regAddrW-1:0] rs1Addr,
   output logic [regAddrW-1:0] rs2Addr,
   output logic                wrEn,
   output logic [regAddrW-1:0] wrAddr,
   output logic [xlen-1:0]     wrData,
   output logic                isStore,
   output logic [xlen-1:0]     storeAddr,
   output logic [xlen-1:0]     storeValue
);

   opcode_t             opcode;
   logic [regAddrW-1:0] rdField;
   logic [xlen-1:0]     uImm;
   logic [xlen-1:0]     sImm;

   logic                isLui;
   logic                isAdd;
   logic                isSw;

   logic [xlen-1:0]     aluB;
   logic [xlen-1:0]     aluOut;

   // field extraction
   assign opcode  = opcode_t'(instr[6:0]);
   assign rdField = instr[11:7];
   assign rs1Addr = instr[19:15];
   assign rs2Addr = instr[24:20];

   // U-type immediate goes to the upper 20 bits
   assign uImm = {instr[31:12], 12'b0};

   // S-type immediate, split field, sign extended
   assign sImm = {{(xlen - 12){instr[31]}}, instr[31:25], instr[11:7]};

   always_comb begin
      isLui = 1'b0;
      isAdd = 1'b0;
      isSw  = 1'b0;
      case (opcode)
         opLui: begin
            isLui = 1'b1;
         end
         opAdd: begin
            isAdd = 1'b1;
         end
         opStore: begin
            isSw = 1'b1;
         end
         default: begin
            // unknown opcode, no-op
            isLui = 1'b0;
         end
      endcase
   end

   // one adder shared by ADD and the store address
   assign aluB   = isSw ? sImm : rs2Data;
   assign aluOut = rs1Data + aluB;

   // register write, committed at the end of the strobe cycle
   assign wrEn   = execStrobe && (isLui || isAdd);
   assign wrAddr = rdField;

   always_comb begin
      if (isLui) begin
         wrData = uImm;
      end
      else begin
         wrData = aluOut;
      end
   end

   // store request towards the sequencer
   assign isStore    = execStrobe && isSw;
   assign storeAddr  = aluOut;
   assign storeValue = rs2Data;

endmodule

`default_nettype wire

/* verilog/miniRvCore.sv */
`default_nettype none

module miniRvCore
   import corePkg::*;
#(
   parameter logic [xlen-1:0] resetPc = '0
) (
   input  logic            clk,
   input  logic            rstn,
   input  logic            runEn,
   input  logic            busValid,
   input  logic [xlen-1:0] busData,
   output logic            busReq,
   output logic            busWrite,
   output logic [xlen-1:0] busAddr,
   output logic [xlen-1:0] storeData
);

   logic [xlen-1:0]     instr;
   logic                execStrobe;
   logic                isStore;
   logic [xlen-1:0]     storeAddr;
   logic [xlen-1:0]     storeValue;

   logic [regAddrW-1:0] rs1Addr;
   logic [regAddrW-1:0] rs2Addr;
   logic [xlen-1:0]     rs1Data;
   logic [xlen-1:0]     rs2Data;
   logic                wrEn;
   logic [regAddrW-1:0] wrAddr;
   logic [xlen-1:0]     wrData;

   busControl #(.resetPc(resetPc)) busControl0 (
      .clk        (clk),
      .rstn       (rstn),
      .runEn      (runEn),
      .busValid   (busValid),
      .busData    (busData),
      .isStore    (isStore),
      .storeAddr  (storeAddr),
      .storeValue (storeValue),
      .busReq     (busReq),
      .busWrite   (busWrite),
      .busAddr    (busAddr),
      .storeData  (storeData),
      .instr      (instr),
      .execStrobe (execStrobe)
   );

   instrExec instrExec0 (
      .instr      (instr),
      .execStrobe (execStrobe),
      .rs1Data    (rs1Data),
      .rs2Data    (rs2Data),
      .rs1Addr    (rs1Addr),
      .rs2Addr    (rs2Addr),
      .wrEn       (wrEn),
      .wrAddr     (wrAddr),
      .wrData     (wrData),
      .isStore    (isStore),
      .storeAddr  (storeAddr),
      .storeValue (storeValue)
   );

   regFile regFile0 (
      .clk     (clk),
      .rstn    (rstn),
      .rs1Addr (rs1Addr),
      .rs2Addr (rs2Addr),
      .wrEn    (wrEn),
      .wrAddr  (wrAddr),
      .wrData  (wrData),
      .rs1Data (rs1Data),
      .rs2Data (rs2Data)
   );

endmodule

`default_nettype wire

/* verilog/regFile.sv */
`default_nettype none

module regFile
   import corePkg::*;
(
   input  logic                clk,
   input  logic                rstn,
   input  logic [regAddrW-1:0] rs1Addr,
   input  logic [regAddrW-1:0] rs2Addr,
   input  logic                wrEn,
   input  logic [regAddrW-1:0] wrAddr,
   input  logic [xlen-1:0]     wrData,
   output logic [xlen-1:0]     rs1Data,
   output logic [xlen-1:0]     rs2Data
);

   localparam int numRegs = 1 << regAddrW;

   logic [xlen-1:0] regs [numRegs];

   logic            wrAllowed;

   // x0 is never written, so it keeps its reset value of zero
   assign wrAllowed = wrEn && (wrAddr != '0);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < numRegs; i++) begin
            regs[i] <= '0;
         end
      end
      else begin
         if (wrAllowed) begin
            regs[wrAddr] <= wrData;
         end
      end
   end

   // combinational read ports
   assign rs1Data = regs[rs1Addr];
   assign rs2Data = regs[rs2Addr];

endmodule

`default_nettype wire
